/* design/ecc_pkg.sv */
package ecc_pkg;

    localparam int DATA_W  = 49;
    localparam int CHECK_W = 7;
    localparam int CODE_W  = DATA_W + CHECK_W;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [CHECK_W-1:0] check_t;
    typedef logic [CODE_W-1:0]  code_t;   // check bits on top, data below

    // ********************
    // syndrome of each data bit, index 0 first
    // every entry has two or more bits set, single-bit syndromes are check-bit errors
    localparam check_t COLUMN_CODE [DATA_W] = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111,
        7'b1001001, 7'b1001010, 7'b0001011, 7'b1001100,
        7'b0001101, 7'b0001110, 7'b1001111, 7'b1010001,
        7'b1010010, 7'b0010011, 7'b1010100, 7'b0010101,
        7'b0010110, 7'b1010111, 7'b1011000, 7'b0011001,
        7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101,
        7'b1011110, 7'b0011111, 7'b1100001, 7'b1100010,
        7'b0100011, 7'b1100100, 7'b0100101, 7'b0100110,
        7'b1100111, 7'b1101000, 7'b0101001, 7'b0101010,
        7'b1101011, 7'b0101100, 7'b1101101, 7'b1101110,
        7'b0101111, 7'b1110000, 7'b0110001, 7'b0110010,
        7'b1110011, 7'b0110100, 7'b1110101, 7'b1110110,
        7'b0110111
    };

    // check bit j is the xor of the data bits whose column code has bit j set
    function automatic check_t ecc_encode(input data_t d);
        check_t p;
        p = '0;
        for (int i = 0; i < DATA_W; i++) begin
            p = p ^ (COLUMN_CODE[i] & {CHECK_W{d[i]}});
        end
        return p;
    endfunction

endpackage

/* design/ecc_49_top.sv */
`timescale 1ns/1ps

module ecc_49_top (
    input  ecc_pkg::code_t code,
    input  logic           bypass,
    output ecc_pkg::data_t data_out,
    output ecc_pkg::code_t code_out,
    output logic           sbit_err,
    output logic           dbit_err
);
    import ecc_pkg::*;

    data_t  raw_data;
    check_t syndrome;
    data_t  flip_mask;
    logic   data_hit;    // syndrome matches a data column
    logic   check_hit;   // syndrome has exactly one bit set

    assign raw_data = code[DATA_W-1:0];
    assign syndrome = code[CODE_W-1:DATA_W] ^ ecc_encode(raw_data);

    // ********************
    // syndrome lookup
    always_comb begin
        flip_mask = '0;
        data_hit  = 1'b0;
        for (int i = 0; i < DATA_W; i++) begin
            if (syndrome == COLUMN_CODE[i]) begin
                flip_mask[i] = 1'b1;
                data_hit     = 1'b1;
            end
        end
    end

    assign check_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    // ********************
    // correction and flags
    assign data_out = bypass ? raw_data : (raw_data ^ flip_mask);
    assign code_out = {ecc_encode(data_out), data_out};   // fresh check bits

    assign sbit_err = !bypass && (data_hit || check_hit);
    assign dbit_err = !bypass && (syndrome != '0) && !data_hit && !check_hit;

endmodule

/* design/ecc_mem_array.sv */
`timescale 1ns/1ps

module ecc_mem_array #(
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  ecc_pkg::code_t    wr_code,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output ecc_pkg::code_t    rd_code
);
    import ecc_pkg::*;

    code_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_code;
        end
    end

    // registered read, old data if the same word is written on this edge
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_code <= mem[rd_addr];
        end
    end

endmodule

/* design/ecc_mem_ctrl.sv */
`timescale 1ns/1ps

module ecc_mem_ctrl #(
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              reset,
    // request
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_write,
    input  logic [ADDR_W-1:0] req_addr,
    input  ecc_pkg::data_t    req_wdata,
    input  ecc_pkg::code_t    req_inject,
    // response
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output ecc_pkg::data_t    rsp_rdata,
    output logic              rsp_sbit_err,
    output logic              rsp_dbit_err,
    input  logic              bypass,
    // array
    output logic              wr_en,
    output logic [ADDR_W-1:0] wr_addr,
    output ecc_pkg::code_t    wr_code,
    output logic              rd_en,
    output logic [ADDR_W-1:0] rd_addr,
    input  ecc_pkg::code_t    rd_code,
    // checker
    output ecc_pkg::code_t    dec_code,
    input  ecc_pkg::data_t    dec_data,
    input  ecc_pkg::code_t    dec_code_out,
    input  logic              dec_sbit,
    input  logic              dec_dbit,
    // error log
    output logic              err_valid,
    output logic              err_sbit,
    output logic              err_dbit,
    output logic [ADDR_W-1:0] err_addr
);
    import ecc_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} state_t;

    state_t            state;
    logic              is_write;   // op of the request in flight
    logic              rd_phase;   // array output is valid this cycle
    logic [ADDR_W-1:0] addr_q;
    logic              accept;
    logic              load_rsp;
    logic              scrub;

    assign accept   = req_valid && req_ready;
    assign load_rsp = (state == ST_WAIT) && (is_write || rd_phase);
    assign scrub    = load_rsp && !is_write && dec_sbit && !bypass;   // one write-back only

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESP);

    // ********************
    // array and checker side
    assign wr_en   = !reset && ((accept && req_write) || scrub);
    assign wr_addr = scrub ? addr_q : req_addr;
    assign wr_code = scrub ? dec_code_out
                           : ({ecc_encode(req_wdata), req_wdata} ^ req_inject);

    assign rd_en    = (state == ST_WAIT) && !is_write && !rd_phase;
    assign rd_addr  = addr_q;
    assign dec_code = rd_code;

    assign err_valid = load_rsp && !is_write;
    assign err_sbit  = dec_sbit;
    assign err_dbit  = dec_dbit;
    assign err_addr  = addr_q;

    // ********************
    // state machine
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            is_write <= 1'b0;
            rd_phase <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    rd_phase <= 1'b0;
                    if (accept) begin
                        is_write <= req_write;
                        state    <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (load_rsp) begin
                        state <= ST_RESP;
                    end else begin
                        rd_phase <= 1'b1;   // read issued this cycle
                    end
                end
                ST_RESP: begin
                    if (rsp_ready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) addr_q <= req_addr;
        if (load_rsp) begin
            rsp_rdata    <= is_write ? '0 : dec_data;
            rsp_sbit_err <= !is_write && dec_sbit;
            rsp_dbit_err <= !is_write && dec_dbit;
        end
    end

endmodule

/* design/ecc_err_log.sv */
`timescale 1ns/1ps

module ecc_err_log #(
    parameter int ADDR_W  = 4,
    parameter int COUNT_W = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               count_clear,
    input  logic               err_valid,
    input  logic               err_sbit,
    input  logic               err_dbit,
    input  logic [ADDR_W-1:0]  err_addr,
    output logic [COUNT_W-1:0] sbit_count,
    output logic [COUNT_W-1:0] dbit_count,
    output logic [ADDR_W-1:0]  last_err_addr
);

    // ********************
    // saturating counters
    always_ff @(posedge clk) begin
        if (reset || count_clear) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else if (err_valid) begin
            if (err_sbit && (sbit_count != '1)) sbit_count <= sbit_count + 1'b1;
            if (err_dbit && (dbit_count != '1)) dbit_count <= dbit_count + 1'b1;
        end
    end

    // address survives count_clear
    always_ff @(posedge clk) begin
        if (reset) begin
            last_err_addr <= '0;
        end else if (err_valid && (err_sbit || err_dbit)) begin
            last_err_addr <= err_addr;
        end
    end

endmodule

/* design/ecc_mem_top.sv */
`timescale 1ns/1ps

module ecc_mem_top #(
    parameter int ADDR_W  = 4,
    parameter int COUNT_W = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    output logic               req_ready,
    input  logic               req_write,
    input  logic [ADDR_W-1:0]  req_addr,
    input  ecc_pkg::data_t     req_wdata,
    input  ecc_pkg::code_t     req_inject,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output ecc_pkg::data_t     rsp_rdata,
    output logic               rsp_sbit_err,
    output logic               rsp_dbit_err,
    input  logic               bypass,
    input  logic               count_clear,
    output logic [COUNT_W-1:0] sbit_count,
    output logic [COUNT_W-1:0] dbit_count,
    output logic [ADDR_W-1:0]  last_err_addr
);
    import ecc_pkg::*;

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    code_t             wr_code;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    code_t             rd_code;
    code_t             dec_code;
    data_t             dec_data;
    code_t             dec_code_out;
    logic              dec_sbit;
    logic              dec_dbit;
    logic              err_valid;
    logic              err_sbit;
    logic              err_dbit;
    logic [ADDR_W-1:0] err_addr;

    ecc_mem_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk, .reset,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata, .req_inject,
        .rsp_valid, .rsp_ready, .rsp_rdata, .rsp_sbit_err, .rsp_dbit_err,
        .bypass,
        .wr_en, .wr_addr, .wr_code, .rd_en, .rd_addr, .rd_code,
        .dec_code, .dec_data, .dec_code_out, .dec_sbit, .dec_dbit,
        .err_valid, .err_sbit, .err_dbit, .err_addr
    );

    ecc_mem_array #(.ADDR_W(ADDR_W)) u_array (
        .clk, .wr_en, .wr_addr, .wr_code, .rd_en, .rd_addr, .rd_code
    );

    // checker sits between array output and response register
    ecc_49_top u_ecc (
        .code     (dec_code),
        .bypass   (bypass),
        .data_out (dec_data),
        .code_out (dec_code_out),
        .sbit_err (dec_sbit),
        .dbit_err (dec_dbit)
    );

    ecc_err_log #(.ADDR_W(ADDR_W), .COUNT_W(COUNT_W)) u_log (
        .clk, .reset, .count_clear,
        .err_valid, .err_sbit, .err_dbit, .err_addr,
        .sbit_count, .dbit_count, .last_err_addr
    );

endmodule

/* sim/ecc_mem_sva.sv */
`timescale 1ns/1ps

module ecc_mem_sva (
    input logic           clk,
    input logic           reset,
    input logic           req_valid,
    input logic           req_ready,
    input logic           req_write,
    input logic           rsp_valid,
    input logic           rsp_ready,
    input ecc_pkg::data_t rsp_rdata,
    input logic           rsp_sbit_err,
    input logic           rsp_dbit_err
);

    // ********************
    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata)
            && $stable(rsp_sbit_err) && $stable(rsp_dbit_err))
        else $error("response changed while rsp_ready was low");

    // idle again only after the pending response has been taken
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        $rose(req_ready) |-> $past(rsp_valid && rsp_ready))
        else $error("req_ready rose without a response transfer");

    // accept sampled three edges back, so rsp_valid rose on the second edge after it
    a_rd_latency: assert property (@(posedge clk) disable iff (reset)
        $past(req_valid && req_ready && !req_write, 3) |-> rsp_valid && !$past(rsp_valid))
        else $error("read response did not rise two edges after acceptance");

endmodule

bind ecc_mem_ctrl ecc_mem_sva u_sva (
    .clk, .reset, .req_valid, .req_ready, .req_write,
    .rsp_valid, .rsp_ready, .rsp_rdata, .rsp_sbit_err, .rsp_dbit_err
);

/* sim/tb_ecc_mem.sv */
`timescale 1ns/1ps

module tb_ecc_mem;
    import ecc_pkg::*;

    localparam int ADDR_W  = 4;
    localparam int COUNT_W = 4;
    localparam int TIMEOUT = 50;   // cycles per wait

    typedef enum int {OP_WR, OP_RD, OP_CLR} op_e;
    typedef enum int {CL_CLEAN, CL_SINGLE, CL_CHECK, CL_DOUBLE} cls_e;   // injected or expected

    typedef struct {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        data_t             data;
        int                pos0;   // injected codeword bits, -1 for none
        int                pos1;
        logic              byp;
        cls_e              cls;
    } row_t;

    logic clk = 1'b0;
    logic reset, req_valid, req_ready, req_write, rsp_valid, rsp_ready;
    logic rsp_sbit_err, rsp_dbit_err, bypass, count_clear;
    logic [ADDR_W-1:0]  req_addr, last_err_addr, exp_last;
    logic [COUNT_W-1:0] sbit_count, dbit_count, exp_sbit, exp_dbit;
    data_t req_wdata, rsp_rdata;
    code_t req_inject;

    row_t  rows [$];
    data_t model_data [2**ADDR_W];   // last written data
    code_t model_code [2**ADDR_W];   // what the array holds
    int    n_checks;
    int    n_errors;
    bit    timed_out;

    always #5 clk = ~clk;

    ecc_mem_top #(.ADDR_W(ADDR_W), .COUNT_W(COUNT_W)) dut (.*);

    // ********************
    task automatic check_data(input string what, input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_flags(input logic [1:0] got, input logic [1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t: flags sbit,dbit expected %b got %b", $time, exp, got);
        end
    endtask

    task automatic check_count(input string what, input logic [COUNT_W-1:0] got,
                               input logic [COUNT_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t: last_err_addr expected %0d got %0d", $time, exp, got);
        end
    endtask

    task automatic add_row(input op_e op, input int a, input logic byp, input cls_e cls);
        row_t r;
        r.op   = op;
        r.addr = a[ADDR_W-1:0];
        r.data = data_t'({$urandom, $urandom});
        r.byp  = byp;
        r.cls  = cls;
        r.pos0 = -1;
        r.pos1 = -1;
        case (cls)
            CL_SINGLE: r.pos0 = int'($urandom_range(DATA_W-1, 0));
            CL_CHECK:  r.pos0 = int'($urandom_range(CODE_W-1, DATA_W));
            CL_DOUBLE: begin
                r.pos0 = int'($urandom_range(CODE_W-1, 0));
                r.pos1 = (r.pos0 + 1 + int'($urandom_range(CODE_W-2, 0))) % CODE_W;
            end
            default: ;
        endcase
        rows.push_back(r);
    endtask

    task automatic wait_req_ready(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++) begin
            @(posedge clk);
            ok = req_ready;
        end
    endtask

    task automatic wait_rsp_valid(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++) begin
            @(posedge clk);
            ok = rsp_valid;
        end
    endtask

    // ********************
    task automatic run_row(input row_t r);
        code_t      inj;
        data_t      exp_data;
        logic [1:0] exp_flags;
        bit         ok;
        inj = '0;
        if (r.pos0 >= 0) inj[r.pos0] = 1'b1;
        if (r.pos1 >= 0) inj[r.pos1] = 1'b1;
        if (r.op == OP_CLR) begin
            count_clear <= 1'b1;
            @(posedge clk);
            count_clear <= 1'b0;
            @(posedge clk);
            exp_sbit = '0;
            exp_dbit = '0;
            check_count("sbit_count", sbit_count, exp_sbit);
            check_count("dbit_count", dbit_count, exp_dbit);
            check_addr(last_err_addr, exp_last);   // kept across the clear
            return;
        end
        req_valid  <= 1'b1;
        req_write  <= (r.op == OP_WR);
        req_addr   <= r.addr;
        req_wdata  <= r.data;
        req_inject <= inj;
        bypass     <= r.byp;
        wait_req_ready(ok);
        req_valid <= 1'b0;
        if (ok) wait_rsp_valid(ok);
        if (!ok) begin
            timed_out = 1'b1;
            $display("timeout: the handshake for addr %0d never completed", r.addr);
            return;
        end
        exp_flags = 2'b00;
        if (r.op == OP_WR) begin
            model_data[r.addr] = r.data;
            model_code[r.addr] = {ecc_encode(r.data), r.data} ^ inj;
            exp_data = '0;
        end else begin
            exp_data = model_data[r.addr];
            if (r.byp || r.cls == CL_DOUBLE) exp_data = model_code[r.addr][DATA_W-1:0];
            if (!r.byp && r.cls == CL_DOUBLE) begin
                exp_flags = 2'b01;
                if (exp_dbit != '1) exp_dbit = exp_dbit + 1'b1;
                exp_last = r.addr;
            end else if (!r.byp && r.cls != CL_CLEAN) begin
                exp_flags = 2'b10;
                if (exp_sbit != '1) exp_sbit = exp_sbit + 1'b1;
                exp_last = r.addr;
                model_code[r.addr] = {ecc_encode(exp_data), exp_data};   // scrubbed
            end
        end
        check_data("rsp_rdata", rsp_rdata, exp_data);
        check_flags({rsp_sbit_err, rsp_dbit_err}, exp_flags);
        check_count("sbit_count", sbit_count, exp_sbit);
        check_count("dbit_count", dbit_count, exp_dbit);
        check_addr(last_err_addr, exp_last);
        repeat ($urandom_range(2, 0)) @(posedge clk);   // hold off the response
        rsp_ready <= 1'b1;
        @(posedge clk);
        rsp_ready <= 1'b0;
    endtask

    initial begin
        int unsigned seed_val;
        int          err_before;
        seed_val = $urandom(32'ha2d9f397);
        reset = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_inject = '0;
        rsp_ready = 1'b0;
        bypass = 1'b0;
        count_clear = 1'b0;
        exp_sbit = '0;
        exp_dbit = '0;
        exp_last = '0;
        add_row(OP_WR, 1, 1'b0, CL_CLEAN);
        add_row(OP_RD, 1, 1'b0, CL_CLEAN);
        add_row(OP_WR, 2, 1'b0, CL_SINGLE);
        add_row(OP_RD, 2, 1'b0, CL_SINGLE);
        add_row(OP_RD, 2, 1'b0, CL_CLEAN);    // write-back took effect
        add_row(OP_WR, 3, 1'b0, CL_CHECK);
        add_row(OP_RD, 3, 1'b0, CL_CHECK);
        add_row(OP_WR, 4, 1'b0, CL_DOUBLE);
        add_row(OP_RD, 4, 1'b0, CL_DOUBLE);
        add_row(OP_RD, 4, 1'b0, CL_DOUBLE);
        add_row(OP_WR, 5, 1'b0, CL_SINGLE);
        add_row(OP_RD, 5, 1'b1, CL_CLEAN);    // bypass, raw data
        add_row(OP_RD, 5, 1'b0, CL_SINGLE);
        for (int k = 0; k < 14; k++) add_row(OP_RD, 4, 1'b0, CL_DOUBLE);   // saturate dbit
        add_row(OP_WR, 6, 1'b0, CL_SINGLE);
        add_row(OP_RD, 6, 1'b0, CL_SINGLE);
        add_row(OP_CLR, 0, 1'b0, CL_CLEAN);
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            err_before = n_errors;
            run_row(rows[i]);
            $display("row %0d %s addr %0d: %s", i, rows[i].op.name(), rows[i].addr,
                     (n_errors == err_before && !timed_out) ? "ok" : "error");
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
design/ecc_pkg.sv
design/ecc_49_top.sv
design/ecc_mem_array.sv
design/ecc_mem_ctrl.sv
design/ecc_err_log.sv
design/ecc_mem_top.sv
sim/ecc_mem_sva.sv
sim/tb_ecc_mem.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ecc scratchpad testbench with verilator
set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing --assert -j 0 --top-module tb_ecc_mem -f src.f -o sim_ecc_mem; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ecc_mem 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1
